// ==== common/s16_video_pkg.sv ====
// Video timing package
// Line and frame layout, pixel pipeline depth, tile map geometry
// and the timing bundle shared by the video blocks

package s16_video_pkg;

    // Line layout in pixels
    localparam logic [8:0] h_total  = 9'd320;
    localparam logic [8:0] h_active = 9'd256;
    localparam logic [8:0] hs_start = 9'd280;
    localparam logic [8:0] hs_len   = 9'd24;

    // Frame layout in lines
    localparam logic [8:0] v_total  = 9'd240;
    localparam logic [8:0] v_active = 9'd224;
    localparam logic [8:0] vs_start = 9'd230;
    localparam logic [8:0] vs_len   = 9'd3;

    // Pixel pipeline depth, in pxl_cen pulses
    localparam int pix_lat = 4;

    // Tile map size, 8x8 tiles
    localparam logic [5:0] cols = 6'd32;
    localparam logic [5:0] rows = 6'd28;

    // 32-bit ROM words: 256 tiles x 8 rows
    localparam int rom_aw = 11;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;
        logic       lvbl;
    } vid_timing_t;

endpackage

// ==== common/s16_bus_pkg.sv ====
// CPU write bus package
// Write strobe bundle and the two readings of the 16-bit data word,
// as a tile map entry or as a palette colour

package s16_bus_pkg;

    // Palette index is {palette, pixel}
    localparam int pal_aw = 8;

    typedef struct packed {
        logic [3:0] spare;
        logic [3:0] pal;
        logic [7:0] code;
    } vram_entry_t;

    // xBBBBBGGGGGRRRRR
    typedef struct packed {
        logic       spare;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } pal_entry_t;

    typedef union packed {
        vram_entry_t vram;
        pal_entry_t  pal;
    } cpu_word_u;

    typedef struct packed {
        logic       we;
        logic       pal_sel;    // 0 VRAM, 1 palette
        logic [9:0] addr;
        cpu_word_u  data;
    } cpu_wr_t;

endpackage

// ==== source/s16_cen.sv ====
// Clock enable generator
// Divides clk by 2 and by 4 for the pixel enables, plus a CPU
// enable in the phase opposite to pxl_cen

module s16_cen(
    input        clk,
    input        arst_n,
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic cpu_cen
);

logic [1:0] cnt;

// Enables are registered so all three are low right after reset
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cnt      <= 2'd0;
        pxl2_cen <= 1'b0;
        pxl_cen  <= 1'b0;
        cpu_cen  <= 1'b0;
    end else begin
        cnt      <= cnt + 2'd1;
        pxl2_cen <= cnt[0];
        // Shares a pulse with pxl2_cen
        pxl_cen  <= cnt == 2'd1;
        // Opposite half of the pixel period
        cpu_cen  <= cnt == 2'd3;
    end
end

endmodule

// ==== video/s16_vtimer.sv ====
// Video timer
// Horizontal and vertical dump counters with sync and blanking,
// all stepping on pxl_cen

module s16_vtimer(
    input                                    clk,
    input                                    arst_n,
    input                                    pxl_cen,
    output s16_video_pkg::vid_timing_t       timing,
    output logic                             HS,
    output logic                             VS
);

logic [8:0] h_next;
logic [8:0] v_next;
logic       line_end;
logic       hs_next;
logic       vs_next;

always_comb begin
    line_end = timing.hdump == s16_video_pkg::h_total - 9'd1;
    h_next   = line_end ? 9'd0 : timing.hdump + 9'd1;
    v_next   = timing.vdump;
    if (line_end) begin
        if (timing.vdump == s16_video_pkg::v_total - 9'd1) begin
            v_next = 9'd0;
        end else begin
            v_next = timing.vdump + 9'd1;
        end
    end
end

// Sync windows
always_comb begin
    hs_next = h_next >= s16_video_pkg::hs_start &&
              h_next <  s16_video_pkg::hs_start + s16_video_pkg::hs_len;
    vs_next = v_next >= s16_video_pkg::vs_start &&
              v_next <  s16_video_pkg::vs_start + s16_video_pkg::vs_len;
end

// Blanks and syncs are decoded from the next count so that they
// line up with the dump values they describe
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        timing.hdump <= 9'd0;
        timing.vdump <= 9'd0;
        // Position (0,0) is inside the active area
        timing.lhbl  <= 1'b1;
        timing.lvbl  <= 1'b1;
        HS           <= 1'b0;
        VS           <= 1'b0;
    end else if (pxl_cen) begin
        timing.hdump <= h_next;
        timing.vdump <= v_next;
        timing.lhbl  <= h_next < s16_video_pkg::h_active;
        timing.lvbl  <= v_next < s16_video_pkg::v_active;
        HS           <= hs_next;
        VS           <= vs_next;
    end
end

endmodule

// ==== video/s16_char.sv ====
// Character layer
// Tile map VRAM and downloadable character ROM, fetched through a
// pipeline that yields one palette/pixel index per pxl_cen

module s16_char(
    input                                      clk,
    input                                      arst_n,
    input                                      pxl_cen,
    input  s16_video_pkg::vid_timing_t         timing,
    // ROM download
    input                                      downloading,
    input                               [12:0] ioctl_addr,
    input                               [ 7:0] ioctl_data,
    input                                      ioctl_wr,
    // CPU writes, VRAM side
    input  s16_bus_pkg::cpu_wr_t               cpu_wr,
    output logic [s16_bus_pkg::pal_aw-1:0]     pxl_col
);

localparam int rom_depth = 1 << s16_video_pkg::rom_aw;

s16_bus_pkg::vram_entry_t vram [0:1023];
logic [3:0][7:0]          rom  [0:rom_depth-1];

logic [9:0] tile_addr;
logic       tile_in;

// Stage 1 outputs
s16_bus_pkg::vram_entry_t vram_q;
logic [2:0] s1_hsub;
logic [2:0] s1_vsub;
logic       s1_vis;

// Stage 2 outputs
logic [7:0][3:0] rom_q;
logic [3:0]      s2_pal;
logic [2:0]      s2_hsub;
logic            s2_vis;

// 32 x 32 map, row major
always_comb begin
    tile_addr = {timing.vdump[7:3], timing.hdump[7:3]};
    tile_in   = timing.hdump[8:3] < s16_video_pkg::cols &&
                timing.vdump[8:3] < s16_video_pkg::rows;
end

always_ff @(posedge clk) begin
    if (cpu_wr.we && !cpu_wr.pal_sel) begin
        vram[cpu_wr.addr] <= cpu_wr.data.vram;
    end
end

// Byte lane from the low address bits
always_ff @(posedge clk) begin
    if (downloading && ioctl_wr) begin
        rom[ioctl_addr[12:2]][ioctl_addr[1:0]] <= ioctl_data;
    end
end

// Stages 1 and 2: tile map read, then pattern row read
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        vram_q  <= vram[tile_addr];
        s1_hsub <= timing.hdump[2:0];
        s1_vsub <= timing.vdump[2:0];

        rom_q   <= rom[{vram_q.code, s1_vsub}];
        s2_pal  <= vram_q.pal;
        s2_hsub <= s1_hsub;
    end
end

// Stage 3: nibble select into the output register
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        s1_vis  <= 1'b0;
        s2_vis  <= 1'b0;
        pxl_col <= '0;
    end else if (pxl_cen) begin
        s1_vis  <= tile_in;
        s2_vis  <= s1_vis;
        // Pixel 0 sits in the low nibble
        pxl_col <= s2_vis ? {s2_pal, rom_q[s2_hsub]} : '0;
    end
end

endmodule

// ==== video/s16_colmix.sv ====
// Colour mixer
// Palette RAM lookup of the layer index into 5-bit RGB, blanked outside
// the active area or when video is disabled, with matching delayed blanks

module s16_colmix(
    input                                      clk,
    input                                      arst_n,
    input                                      pxl_cen,
    input  s16_video_pkg::vid_timing_t         timing,
    input        [s16_bus_pkg::pal_aw-1:0]     pxl_col,
    // CPU writes, palette side
    input  s16_bus_pkg::cpu_wr_t               cpu_wr,
    input                                      video_en,
    output logic [4:0]                         red,
    output logic [4:0]                         green,
    output logic [4:0]                         blue,
    output logic                               LHBL_dly,
    output logic                               LVBL_dly
);

localparam int lat = s16_video_pkg::pix_lat;

s16_bus_pkg::pal_entry_t pal_ram [0:(1 << s16_bus_pkg::pal_aw)-1];
s16_bus_pkg::pal_entry_t rgb_q;

logic [lat-1:0] lhbl_sr;
logic [lat-1:0] lvbl_sr;
logic           show;

always_ff @(posedge clk) begin
    if (cpu_wr.we && cpu_wr.pal_sel) begin
        pal_ram[cpu_wr.addr[s16_bus_pkg::pal_aw-1:0]] <= cpu_wr.data.pal;
    end
end

// Blanks entering the last stage, together with video_en
assign show = lhbl_sr[lat-2] && lvbl_sr[lat-2] && video_en;

// Last pipeline stage: palette read and blanking
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        lhbl_sr <= '0;
        lvbl_sr <= '0;
        rgb_q   <= '0;
    end else if (pxl_cen) begin
        lhbl_sr <= {lhbl_sr[lat-2:0], timing.lhbl};
        lvbl_sr <= {lvbl_sr[lat-2:0], timing.lvbl};
        rgb_q   <= show ? pal_ram[pxl_col] : '0;
    end
end

assign red      = rgb_q.red;
assign green    = rgb_q.green;
assign blue     = rgb_q.blue;
assign LHBL_dly = lhbl_sr[lat-1];
assign LVBL_dly = lvbl_sr[lat-1];

endmodule

// ==== source/s16_game.sv ====
// Arcade video board top level
// Enable generator plus the video chain: timer, character layer
// and colour mixer. ROM download and CPU writes go straight to the layers

module s16_game(
    input                        clk,
    input                        arst_n,
    output                       pxl2_cen,   // 12 MHz style
    output                       pxl_cen,    //  6 MHz style
    output                [4:0]  red,
    output                [4:0]  green,
    output                [4:0]  blue,
    output                       LHBL_dly,
    output                       LVBL_dly,
    output                       HS,
    output                       VS,
    // ROM download
    input                        downloading,
    input                 [12:0] ioctl_addr,
    input                 [ 7:0] ioctl_data,
    input                        ioctl_wr,
    // CPU side writes
    input  s16_bus_pkg::cpu_wr_t cpu_wr,
    input                        video_en
);

s16_video_pkg::vid_timing_t timing;
wire [s16_bus_pkg::pal_aw-1:0] pxl_col;

s16_cen u_cen(
    .clk        ( clk         ),
    .arst_n     ( arst_n      ),
    .pxl2_cen   ( pxl2_cen    ),
    .pxl_cen    ( pxl_cen     ),
    .cpu_cen    (             )
);

s16_vtimer u_vtimer(
    .clk        ( clk         ),
    .arst_n     ( arst_n      ),
    .pxl_cen    ( pxl_cen     ),
    .timing     ( timing      ),
    .HS         ( HS          ),
    .VS         ( VS          )
);

s16_char u_char(
    .clk        ( clk         ),
    .arst_n     ( arst_n      ),
    .pxl_cen    ( pxl_cen     ),
    .timing     ( timing      ),
    .downloading( downloading ),
    .ioctl_addr ( ioctl_addr  ),
    .ioctl_data ( ioctl_data  ),
    .ioctl_wr   ( ioctl_wr    ),
    .cpu_wr     ( cpu_wr      ),
    .pxl_col    ( pxl_col     )
);

s16_colmix u_colmix(
    .clk        ( clk         ),
    .arst_n     ( arst_n      ),
    .pxl_cen    ( pxl_cen     ),
    .timing     ( timing      ),
    .pxl_col    ( pxl_col     ),
    .cpu_wr     ( cpu_wr      ),
    .video_en   ( video_en    ),
    .red        ( red         ),
    .green      ( green       ),
    .blue       ( blue        ),
    .LHBL_dly   ( LHBL_dly    ),
    .LVBL_dly   ( LVBL_dly    )
);

endmodule

// ==== verification/s16_game_chk.sv ====
// Game board checker
// Concurrent assertions on the clock enables, sync width and blanking

module s16_game_chk(
    input       clk,
    input       arst_n,
    input       pxl2_cen,
    input       pxl_cen,
    input       HS,
    input [4:0] red,
    input [4:0] green,
    input [4:0] blue,
    input       LHBL_dly
);

timeunit 1ns;
timeprecision 1ps;

logic [8:0] hs_cnt;

// Pixel pulses seen while HS is high
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        hs_cnt <= 9'd0;
    end else if (pxl_cen) begin
        hs_cnt <= HS ? hs_cnt + 9'd1 : 9'd0;
    end
end

a_cen_nested: assert property (@(posedge clk) disable iff (!arst_n)
    pxl_cen |-> pxl2_cen) else $error("pxl_cen without pxl2_cen");

a_cen_single: assert property (@(posedge clk) disable iff (!arst_n)
    pxl_cen |=> !pxl_cen) else $error("pxl_cen on two consecutive clocks");

a_hs_width: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(HS) |-> hs_cnt == s16_video_pkg::hs_len) else $error("HS width wrong");

a_hblank_black: assert property (@(posedge clk) disable iff (!arst_n)
    !LHBL_dly |-> {red, green, blue} == 15'd0) else $error("colour during blank");

endmodule

bind s16_game s16_game_chk u_chk(
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .pxl2_cen ( pxl2_cen ),
    .pxl_cen  ( pxl_cen  ),
    .HS       ( HS       ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     ),
    .LHBL_dly ( LHBL_dly )
);

// ==== verification/s16_game_tb.sv ====
// Game board testbench
// Random ROM, VRAM and palette contents checked pixel by pixel
// against a reference model of the video chain

module s16_game_tb;

timeunit 1ns;
timeprecision 1ps;

logic                 clk;
logic                 arst_n;
logic                 downloading;
logic [12:0]          ioctl_addr;
logic [7:0]           ioctl_data;
logic                 ioctl_wr;
s16_bus_pkg::cpu_wr_t cpu_wr;
logic                 video_en;
wire                  pxl2_cen;
wire                  pxl_cen;
wire  [4:0]           red;
wire  [4:0]           green;
wire  [4:0]           blue;
wire                  LHBL_dly;
wire                  LVBL_dly;
wire                  HS;
wire                  VS;

// Reference memories
logic [31:0] rom_m  [0:2047];
logic [15:0] vram_m [0:1023];
logic [15:0] pal_m  [0:255];
logic [15:0] lfsr;

s16_game u_s16_game(
    .clk(clk), .arst_n(arst_n), .pxl2_cen(pxl2_cen), .pxl_cen(pxl_cen),
    .red(red), .green(green), .blue(blue), .LHBL_dly(LHBL_dly),
    .LVBL_dly(LVBL_dly), .HS(HS), .VS(VS), .downloading(downloading),
    .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
    .cpu_wr(cpu_wr), .video_en(video_en)
);

always #5 clk = ~clk;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic [14:0] expected_rgb(input logic [8:0] h, input logic [8:0] v);
    logic [15:0] tile;
    logic [31:0] row;
    logic [3:0]  nib;
    logic [15:0] col;
    tile = vram_m[{v[7:3], h[7:3]}];
    row  = rom_m[{tile[7:0], v[2:0]}];
    nib  = row[4*h[2:0] +: 4];
    col  = pal_m[{tile[11:8], nib}];
    if (!video_en) begin
        return 15'd0;
    end
    return {col[4:0], col[9:5], col[14:10]};
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED %s got %h expected %h", name, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1);
    end
endtask

task automatic timeout(input string what);
    $display("Timeout: %s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
endtask

task automatic step();
    @(posedge clk);
    #1;
endtask

// Next clock with pxl_cen high, sampled on the falling edge
task automatic wait_pxl();
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (n > 8) timeout("no pxl_cen pulse within eight clocks");
    end while (!pxl_cen);
endtask

// pxl2_cen on every second clock, pxl_cen on every fourth
task automatic check_enables();
    for (int k = 0; k < 8; k++) begin
        check("pxl2_cen", pxl2_cen, (k % 2) == 0);
        check("pxl_cen", pxl_cen, (k % 4) == 0);
        @(negedge clk);
    end
endtask

task automatic wait_vblank();
    int n;
    n = 0;
    do begin
        wait_pxl();
        n++;
        if (n > 80000) timeout("LVBL_dly never went low");
    end while (LVBL_dly);
endtask

task automatic measure_geometry();
    int  n;
    int  pix;
    int  act;
    int  lines;
    int  vact;
    logic prev;
    logic prev_hs;
    n = 0;
    prev = 1'b1;
    // Align to an HS rise
    do begin
        prev = HS;
        wait_pxl();
        n++;
        if (n > 400) timeout("HS never rose");
    end while (!(HS && !prev));
    pix = 0;
    act = 0;
    do begin
        prev = HS;
        wait_pxl();
        pix++;
        act += LHBL_dly;
        if (pix > 400) timeout("second HS rise missing");
    end while (!(HS && !prev));
    check("h_total", pix, s16_video_pkg::h_total);
    check("h_active", act, s16_video_pkg::h_active);
    n = 0;
    do begin
        prev = VS;
        wait_pxl();
        n++;
        if (n > 80000) timeout("VS never rose");
    end while (!(VS && !prev));
    lines = 0;
    vact = 0;
    n = 0;
    do begin
        prev = VS;
        prev_hs = HS;
        wait_pxl();
        n++;
        // One line per HS rise
        if (HS && !prev_hs) begin
            lines++;
            vact += LVBL_dly;
        end
        if (n > 80000) timeout("second VS rise missing");
    end while (!(VS && !prev));
    check("v_total", lines, s16_video_pkg::v_total);
    check("v_active", vact, s16_video_pkg::v_active);
endtask

task automatic check_frame();
    int n;
    for (int v = 0; v < s16_video_pkg::v_active; v++) begin
        for (int h = 0; h < s16_video_pkg::h_active; h++) begin
            n = 0;
            do begin
                wait_pxl();
                n++;
                if (n > 30000) timeout("active pixel never arrived");
            end while (!(LHBL_dly && LVBL_dly));
            check("rgb", {red, green, blue}, expected_rgb(h[8:0], v[8:0]));
        end
    end
endtask

task automatic cpu_write(input logic sel, input logic [9:0] addr, input logic [15:0] data);
    step();
    cpu_wr.we      = 1'b1;
    cpu_wr.pal_sel = sel;
    cpu_wr.addr    = addr;
    cpu_wr.data    = data;
    if (sel) pal_m[addr[7:0]] = data;
    else vram_m[addr] = data;
endtask

task automatic write_palette();
    for (int i = 0; i < 256; i++) begin
        cpu_write(1'b1, i[9:0], rand_bits(16));
    end
    step();
    cpu_wr.we = 1'b0;
endtask

task automatic rom_byte(input logic [12:0] addr, input logic [7:0] data);
    step();
    ioctl_wr   = 1'b1;
    ioctl_addr = addr;
    ioctl_data = data;
    if (downloading) rom_m[addr[12:2]][8*addr[1:0] +: 8] = data;
endtask

initial begin
    int n;
    clk         = 1'b0;
    arst_n      = 1'b0;
    downloading = 1'b0;
    ioctl_addr  = '0;
    ioctl_data  = '0;
    ioctl_wr    = 1'b0;
    cpu_wr      = '0;
    video_en    = 1'b1;
    lfsr        = 16'd3;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Quiet outputs after reset
    @(negedge clk);
    check("HS", HS, 0);
    check("VS", VS, 0);
    check("LHBL_dly", LHBL_dly, 0);
    check("LVBL_dly", LVBL_dly, 0);
    check("rgb", {red, green, blue}, 0);
    check("pxl_cen", pxl_cen, 0);
    check("pxl2_cen", pxl2_cen, 0);
    n = 1;
    while (!pxl_cen) begin
        @(negedge clk);
        n++;
        if (n > 4) timeout("first pxl_cen later than four clocks");
    end
    check_enables();

    measure_geometry();

    // ROM download, whole address space
    downloading = 1'b1;
    for (int a = 0; a < 8192; a++) begin
        rom_byte(a[12:0], rand_bits(8));
    end
    step();
    ioctl_wr    = 1'b0;
    downloading = 1'b0;

    wait_vblank();
    for (int i = 0; i < 1024; i++) begin
        cpu_write(1'b0, i[9:0], rand_bits(16));
    end
    write_palette();
    check_frame();

    // New palette, same tile map
    wait_vblank();
    write_palette();
    check_frame();

    // Strobes outside the download window
    wait_vblank();
    for (int i = 0; i < 64; i++) begin
        rom_byte(rand_bits(13), rand_bits(8));
    end
    step();
    ioctl_wr = 1'b0;
    check_frame();

    wait_vblank();
    step();
    video_en = 1'b0;
    check_frame();
    wait_vblank();
    step();
    video_en = 1'b1;
    check_frame();

    $display("SIMULATION PASSED");
    $finish;
end

endmodule

// ==== verilog.f ====
common/s16_video_pkg.sv
common/s16_bus_pkg.sv
source/s16_cen.sv
video/s16_vtimer.sv
video/s16_char.sv
video/s16_colmix.sv
source/s16_game.sv
verification/s16_game_chk.sv
verification/s16_game_tb.sv

// ==== Makefile ====
# Verilator build for the arcade video board

VERILATOR ?= verilator
TOP       ?= s16_game_tb
FLIST     ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

sim: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
